// File: Bender.yml
package:
  name: mlp

sources:
  - files:
      - hdl/mlpTypes.sv
      - hdl/mlpWeights.sv
      - hdl/vectorBus.sv
      - hdl/featureCollector.sv
      - hdl/neuron.sv
      - hdl/denseLayer.sv
      - hdl/scoreSerializer.sv
      - hdl/mlpTop.sv
  - target: test
    files:
      - tests/mlpTb.sv

// File: hdl/denseLayer.sv
`timescale 1ns/1ps
`default_nettype none

module denseLayer #(
	parameter mlpTypes::layerId_t Layer = mlpTypes::hiddenLayer,
	parameter int FanIn = mlpWeights::NumInputs,
	parameter int Nodes = mlpWeights::NumHidden
) (
	input logic clk,
	input logic reset,
	vectorBus.sink src,
	vectorBus.source dst
);

	logic [Nodes-1:0] nodeValid;

	for (genvar n = 0; n < Nodes; n++)
	begin : genNode
		neuron #(
			.Layer(Layer),
			.Node(n),
			.FanIn(FanIn)
		) neuron_inst (
			.clk(clk),
			.reset(reset),
			.inValid(src.valid),
			.inData(src.data), // every node sees the whole vector
			.outValid(nodeValid[n]),
			.outAct(dst.data[n])
		);
	end

	// all nodes share the same latency, node 0 stands for the layer
	assign dst.valid = nodeValid[0];

endmodule

`default_nettype wire

// File: hdl/featureCollector.sv
`timescale 1ns/1ps
`default_nettype none

module featureCollector (
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic inFirst,
	input mlpTypes::activation_t inData,
	vectorBus.source vec
);
	import mlpWeights::*;

	logic [$clog2(NumInputs)-1:0] count; // next element to write
	logic collecting; // set once element 0 has arrived

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			count <= '0;
			collecting <= 1'b0;
			vec.valid <= 1'b0;
			vec.data <= '{default: '0};
		end
		else
		begin
			vec.valid <= 1'b0;
			if (inValid && inFirst)
			begin
				// restart, any partial vector is dropped
				vec.data[0] <= inData;
				count <= $bits(count)'(1);
				collecting <= 1'b1;
			end
			else if (inValid && collecting)
			begin
				vec.data[count] <= inData;
				count <= count + 1'b1;
				if (count == $bits(count)'(NumInputs - 1))
				begin
					collecting <= 1'b0; // wait for the next first element
					vec.valid <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/mlpTop.sv
`timescale 1ns/1ps
`default_nettype none

module mlpTop (
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic inFirst,
	input mlpTypes::activation_t inData,
	output logic outValid,
	output logic [1:0] outIndex,
	output mlpTypes::activation_t outScore,
	output logic outLast,
	output logic [1:0] outClass
);
	import mlpTypes::*;
	import mlpWeights::*;

	vectorBus #(.Width(NumInputs)) featureVec ();
	vectorBus #(.Width(NumHidden)) hiddenVec ();
	vectorBus #(.Width(NumOutputs)) scoreVec ();

	featureCollector featureCollector_inst (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inFirst(inFirst),
		.inData(inData),
		.vec(featureVec.source)
	);

	denseLayer #(
		.Layer(hiddenLayer),
		.FanIn(NumInputs),
		.Nodes(NumHidden)
	) hiddenLayer_inst (
		.clk(clk),
		.reset(reset),
		.src(featureVec.sink),
		.dst(hiddenVec.source)
	);

	denseLayer #(
		.Layer(outputLayer),
		.FanIn(NumHidden),
		.Nodes(NumOutputs)
	) outputLayer_inst (
		.clk(clk),
		.reset(reset),
		.src(hiddenVec.sink),
		.dst(scoreVec.source)
	);

	scoreSerializer scoreSerializer_inst (
		.clk(clk),
		.reset(reset),
		.scores(scoreVec.sink),
		.outValid(outValid),
		.outIndex(outIndex),
		.outScore(outScore),
		.outLast(outLast),
		.outClass(outClass)
	);

endmodule

`default_nettype wire

// File: hdl/mlpTypes.sv
`default_nettype none

package mlpTypes;

	localparam int ActWidth = 8;
	localparam int AccWidth = 23;
	localparam int FracBits = 6; // fraction bits dropped after the accumulator
	localparam int ActMax = 127;

	typedef logic signed [ActWidth-1:0] activation_t;
	typedef logic signed [AccWidth-1:0] accum_t;

	// selects which weight table a node reads
	typedef enum logic
	{
		hiddenLayer,
		outputLayer
	} layerId_t;

	typedef enum logic
	{
		idle,
		sending
	} serState_t;

endpackage

`default_nettype wire

// File: hdl/mlpWeights.sv
`default_nettype none

package mlpWeights;

	localparam int NumInputs = 5;
	localparam int NumHidden = 4;
	localparam int NumOutputs = 3;
	localparam int MaxFanIn = 5;

	localparam int WeightWidth = 8;
	localparam int BiasWidth = 16;

	localparam logic signed [WeightWidth-1:0] hiddenWeights [NumHidden][NumInputs] = '{
		'{8'sd2, 8'sd54, -8'sd22, -8'sd34, 8'sd48},
		'{-8'sd41, 8'sd17, 8'sd63, 8'sd9, -8'sd28},
		'{8'sd35, -8'sd12, 8'sd27, -8'sd50, 8'sd19},
		'{-8'sd8, 8'sd44, -8'sd31, 8'sd22, 8'sd57}
	};

	// biases sit on the accumulator scale, already times 64
	localparam logic signed [BiasWidth-1:0] hiddenBias [NumHidden] = '{
		16'sd512, -16'sd256, 16'sd1024, 16'sd0
	};

	localparam logic signed [WeightWidth-1:0] outputWeights [NumOutputs][NumHidden] = '{
		'{8'sd23, -8'sd45, 8'sd38, 8'sd11},
		'{-8'sd19, 8'sd52, 8'sd7, -8'sd33},
		'{8'sd41, 8'sd14, -8'sd27, 8'sd36}
	};

	localparam logic signed [BiasWidth-1:0] outputBias [NumOutputs] = '{
		-16'sd640, 16'sd320, -16'sd128
	};

endpackage

`default_nettype wire

// File: hdl/neuron.sv
`timescale 1ns/1ps
`default_nettype none

module neuron #(
	parameter mlpTypes::layerId_t Layer = mlpTypes::hiddenLayer,
	parameter int Node = 0, // row in the weight table
	parameter int FanIn = mlpWeights::MaxFanIn
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	input mlpTypes::activation_t inData [FanIn],
	output logic outValid,
	output mlpTypes::activation_t outAct
);
	import mlpTypes::*;
	import mlpWeights::*;

	logic signed [WeightWidth-1:0] weight [FanIn];
	logic signed [BiasWidth-1:0] bias;

	activation_t inReg [FanIn];
	accum_t sum;
	accum_t acc;
	accum_t rounded;
	activation_t actNext;
	logic [2:0] validPipe; // in, accumulate, activate

	if (Layer == hiddenLayer)
	begin : genHiddenRow
		assign bias = hiddenBias[Node];
		for (genvar i = 0; i < FanIn; i++)
		begin : genTap
			assign weight[i] = hiddenWeights[Node][i];
		end
	end
	else
	begin : genOutputRow
		assign bias = outputBias[Node];
		for (genvar i = 0; i < FanIn; i++)
		begin : genTap
			assign weight[i] = outputWeights[Node][i];
		end
	end

	always_comb
	begin
		sum = accum_t'(bias);
		for (int i = 0; i < FanIn; i++)
			sum += accum_t'(inReg[i]) * accum_t'(weight[i]);
	end

	// round half up, then clamp; negative sums rectify to zero
	always_comb
	begin
		rounded = (acc + (accum_t'(1) <<< (FracBits - 1))) >>> FracBits;
		if (acc[AccWidth-1])
			actNext = '0;
		else if (rounded > accum_t'(ActMax))
			actNext = activation_t'(ActMax);
		else
			actNext = activation_t'(rounded);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inReg <= '{default: '0};
			acc <= '0;
			outAct <= '0;
			validPipe <= '0;
		end
		else
		begin
			if (inValid)
				inReg <= inData;
			acc <= sum;
			outAct <= actNext;
			validPipe <= {validPipe[1:0], inValid};
		end
	end

	assign outValid = validPipe[2];

endmodule

`default_nettype wire

// File: hdl/scoreSerializer.sv
`timescale 1ns/1ps
`default_nettype none

module scoreSerializer (
	input logic clk,
	input logic reset,
	vectorBus.sink scores,
	output logic outValid,
	output logic [1:0] outIndex,
	output mlpTypes::activation_t outScore,
	output logic outLast,
	output logic [1:0] outClass
);
	import mlpTypes::*;
	import mlpWeights::*;

	serState_t state;
	activation_t held [NumOutputs];
	logic [1:0] winner;
	logic [1:0] winnerNext;

	// strict compare keeps the lowest index on a tie
	always_comb
	begin
		winnerNext = '0;
		for (int i = 1; i < NumOutputs; i++)
			if (scores.data[i] > scores.data[winnerNext])
				winnerNext = 2'(i);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
			held <= '{default: '0};
			winner <= '0;
			outValid <= 1'b0;
			outIndex <= '0;
			outScore <= '0;
			outLast <= 1'b0;
			outClass <= '0;
		end
		else
		begin
			outValid <= 1'b0;
			outLast <= 1'b0;
			case (state)
				idle:
				begin
					if (scores.valid)
					begin
						held <= scores.data;
						winner <= winnerNext;
						outValid <= 1'b1;
						outIndex <= '0;
						outScore <= scores.data[0]; // index 0 goes out right away
						state <= sending;
					end
				end
				sending:
				begin
					outValid <= 1'b1;
					outIndex <= outIndex + 1'b1;
					outScore <= held[outIndex + 1'b1];
					if (outIndex == 2'(NumOutputs - 2))
					begin
						outLast <= 1'b1;
						outClass <= winner;
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/vectorBus.sv
`timescale 1ns/1ps
`default_nettype none

interface vectorBus #(
	parameter int Width = 5 // element count
);
	import mlpTypes::*;

	logic valid; // one-cycle strobe
	activation_t data [Width];

	modport source
	(
		output valid,
		output data
	);

	modport sink
	(
		input valid,
		input data
	);

endinterface

`default_nettype wire

// File: src.f
hdl/mlpTypes.sv
hdl/mlpWeights.sv
hdl/vectorBus.sv
hdl/featureCollector.sv
hdl/neuron.sv
hdl/denseLayer.sv
hdl/scoreSerializer.sv
hdl/mlpTop.sv
tests/mlpTb.sv

// File: tests/mlpTb.sv
`timescale 1ns/1ps
`default_nettype none

module mlpTb;
	import mlpTypes::*;
	import mlpWeights::*;

	localparam int ClkPeriod = 40;
	localparam int Latency = 8; // element 4 strobe to index 0
	localparam int MaxGap = 3;
	localparam int NumVectors = 46;
	localparam int StrayCount = 2 * NumInputs; // enough to wrap any element counter
	localparam int VectorCycles = NumInputs * (MaxGap + 1) + 4;
	localparam int TimeoutNs = (NumVectors * VectorCycles + 5 * StrayCount + 200) * ClkPeriod;

	logic clk;
	logic reset;
	logic inValid;
	logic inFirst;
	activation_t inData;
	logic outValid;
	logic [1:0] outIndex;
	activation_t outScore;
	logic outLast;
	logic [1:0] outClass;

	logic [31:0] lfsr = 32'h1108;
	int cycleCount = 0;
	int mismatches = 0;
	int lostCount = 0; // missing, extra or late outputs
	int scorePos = 0;

	// collector model
	activation_t feat [NumInputs];
	int featCount = 0;
	logic collecting = 1'b0;

	activation_t expScore [$];
	logic [1:0] expClass [$];
	int expCycle [$];

	mlpTop mlpTop_inst (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inFirst(inFirst),
		.inData(inData),
		.outValid(outValid),
		.outIndex(outIndex),
		.outScore(outScore),
		.outLast(outLast),
		.outClass(outClass)
	);

	initial
	begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	always @(posedge clk)
		cycleCount <= cycleCount + 1;

	function automatic logic stepLfsr();
		logic bitOut;
		bitOut = lfsr[0];
		lfsr = (lfsr >> 1) ^ (bitOut ? 32'h8020_0003 : 32'h0);
		return bitOut;
	endfunction

	function automatic logic [31:0] randBits(int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
			r = {r[30:0], stepLfsr()};
		return r;
	endfunction

	// rectify, round half up, saturate
	function automatic activation_t activate(int sum);
		int r;
		if (sum < 0)
			return '0;
		r = (sum + 32) >>> FracBits;
		if (r > ActMax)
			return activation_t'(ActMax);
		return activation_t'(r);
	endfunction

	task automatic expectVector();
		int acc;
		activation_t hid [NumHidden];
		activation_t score [NumOutputs];
		logic [1:0] best;
		for (int n = 0; n < NumHidden; n++)
		begin
			acc = int'(hiddenBias[n]);
			for (int i = 0; i < NumInputs; i++)
				acc += int'(feat[i]) * int'(hiddenWeights[n][i]);
			hid[n] = activate(acc);
		end
		for (int o = 0; o < NumOutputs; o++)
		begin
			acc = int'(outputBias[o]);
			for (int i = 0; i < NumHidden; i++)
				acc += int'(hid[i]) * int'(outputWeights[o][i]);
			score[o] = activate(acc);
		end
		best = '0;
		for (int o = 1; o < NumOutputs; o++)
			if (score[o] > score[best])
				best = 2'(o); // ties keep the lower index
		for (int o = 0; o < NumOutputs; o++)
			expScore.push_back(score[o]);
		expClass.push_back(best);
		expCycle.push_back(cycleCount + Latency);
	endtask

	task automatic driveStrobe(logic first, activation_t value);
		@(negedge clk);
		inValid = 1'b1;
		inFirst = first;
		inData = value;
		if (first)
		begin
			feat[0] = value;
			featCount = 1;
			collecting = 1'b1;
		end
		else if (collecting)
		begin
			feat[featCount] = value;
			featCount++;
			if (featCount == NumInputs)
			begin
				collecting = 1'b0;
				expectVector();
			end
		end
	endtask

	task automatic idleCycles(int n);
		repeat (n)
		begin
			@(negedge clk);
			inValid = 1'b0;
			inFirst = 1'b0;
			inData = activation_t'(randBits(8)); // noise on an idle bus
		end
	endtask

	// strobes without a first element, none of them may start a vector
	task automatic strayStrobes(int n);
		for (int i = 0; i < n; i++)
			driveStrobe(1'b0, activation_t'(randBits(8)));
	endtask

	task automatic sendVector(int maxGap);
		int gap;
		for (int i = 0; i < NumInputs; i++)
		begin
			driveStrobe(i == 0, activation_t'(randBits(8)));
			gap = (maxGap == 0) ? 0 : int'(randBits(2));
			idleCycles(gap);
		end
	endtask

	task automatic compareScore(string name, activation_t actual, activation_t expected);
		if (actual !== expected)
		begin
			mismatches++;
			$display("Mismatch %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	task automatic compareClass(string name, logic [1:0] actual, logic [1:0] expected);
		if (actual !== expected)
		begin
			mismatches++;
			$display("Mismatch %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	always @(negedge clk)
	begin
		if (!reset && outValid)
		begin
			if (expScore.size() == 0)
			begin
				lostCount++;
				$display("unexpected output at cycle %0d", cycleCount);
			end
			else
			begin
				if (scorePos == 0)
				begin
					if (cycleCount != expCycle[0])
					begin
						lostCount++;
						$display("first score came at cycle %0d, expected at cycle %0d",
							cycleCount, expCycle[0]);
					end
					expCycle.delete(0);
				end
				compareScore("outIndex", activation_t'(outIndex), activation_t'(scorePos));
				compareScore("outScore", outScore, expScore.pop_front());
				compareScore("outLast", activation_t'(outLast), activation_t'(scorePos == 2));
				if (scorePos == NumOutputs - 1)
				begin
					compareClass("outClass", outClass, expClass.pop_front());
					scorePos = 0;
				end
				else
					scorePos++;
			end
		end
		else if (!reset)
		begin
			if (outLast)
			begin
				lostCount++;
				$display("outLast high without outValid at cycle %0d", cycleCount);
			end
			if (scorePos != 0)
			begin
				lostCount++;
				$display("score burst broke off after %0d scores", scorePos);
				repeat (NumOutputs - scorePos) expScore.delete(0);
				expClass.delete(0);
				scorePos = 0;
			end
			else if (expCycle.size() > 0 && cycleCount >= expCycle[0])
			begin
				lostCount++;
				$display("no output for the vector due at cycle %0d", expCycle[0]);
				expCycle.delete(0);
				expClass.delete(0);
				repeat (NumOutputs) expScore.delete(0);
			end
		end
	end

	initial
	begin
		#(TimeoutNs);
		$display("watchdog expired after %0d ns, the run did not finish", TimeoutNs);
		$display("** FAIL **");
		$finish;
	end

	initial
	begin
		reset = 1'b1;
		inValid = 1'b0;
		inFirst = 1'b0;
		inData = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		idleCycles(4);

		// strobes before any first element
		strayStrobes(StrayCount);
		idleCycles(12);

		repeat (30) sendVector(MaxGap);

		// restart mid vector, then stray strobes after completion
		repeat (4)
		begin
			driveStrobe(1'b1, activation_t'(randBits(8)));
			driveStrobe(1'b0, activation_t'(randBits(8)));
			idleCycles(1);
			sendVector(MaxGap);
			strayStrobes(StrayCount);
			idleCycles(2);
		end

		repeat (8) sendVector(0); // several vectors in flight
		idleCycles(Latency + 8);

		if (expScore.size() != 0)
		begin
			lostCount++;
			$display("%0d expected scores never appeared", expScore.size());
		end
		$display("errors: %0d value mismatches, %0d missing or extra outputs",
			mismatches, lostCount);
		if (mismatches + lostCount == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire
